//--- tag_pkg.sv
package tag_pkg;

  // tag pool

  // tags that can be in flight at once
  localparam int num_ids_lp = 8;

  // bits needed to name one tag
  localparam int id_width_lp = 3;

  // request and response fields

  // memory request address
  localparam int addr_width_lp = 16;

  // requester context, returned with the response
  localparam int ctx_width_lp = 8;

  // memory response data
  localparam int data_width_lp = 32;

endpackage

//--- id_pool.sv
`timescale 1ns/10ps

module id_pool (
    input  logic                            clk_i
  , input  logic                            reset_i

  // lowest free tag, valid when any tag is free
  , output logic                            alloc_v_o
  , output logic [tag_pkg::id_width_lp-1:0] alloc_id_o
  , input  logic                            alloc_yumi_i

  // tag coming back from the response side
  , input  logic                            dealloc_v_i
  , input  logic [tag_pkg::id_width_lp-1:0] dealloc_id_i
);

  // one bit per tag, set while the tag is out
  logic [tag_pkg::num_ids_lp-1:0] allocated_r;

  logic [tag_pkg::num_ids_lp-1:0] alloc_oh;
  logic [tag_pkg::num_ids_lp-1:0] dealloc_oh;
  logic [tag_pkg::id_width_lp-1:0] alloc_id_lo;
  logic                            found_lo;

  // priority search from tag 0 upward, registered state only
  always_comb begin
    alloc_oh    = '0;
    alloc_id_lo = '0;
    found_lo    = 1'b0;
    for (int i = 0; i < tag_pkg::num_ids_lp; i++) begin
      if (!allocated_r[i] && !found_lo) begin
        alloc_oh[i] = 1'b1;
        alloc_id_lo = i[tag_pkg::id_width_lp-1:0];
        found_lo    = 1'b1;
      end
    end
  end

  assign alloc_v_o  = found_lo;
  assign alloc_id_o = alloc_id_lo;

  // decode of the returned tag
  always_comb begin
    dealloc_oh = '0;
    if (dealloc_v_i) begin
      dealloc_oh[dealloc_id_i] = 1'b1;
    end
  end

  // a release beats an allocation of the same bit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      allocated_r <= '0;
    end else begin
      for (int i = 0; i < tag_pkg::num_ids_lp; i++) begin
        if (dealloc_oh[i]) begin
          allocated_r[i] <= 1'b0;
        end else if (alloc_oh[i] && alloc_yumi_i) begin
          allocated_r[i] <= 1'b1;
        end
      end
    end
  end

endmodule

//--- req_issue.sv
`timescale 1ns/10ps

module req_issue (
    input  logic                              clk_i
  , input  logic                              reset_i

  // requester side
  , input  logic                              req_v_i
  , input  logic [tag_pkg::addr_width_lp-1:0] req_addr_i
  , input  logic [tag_pkg::ctx_width_lp-1:0]  req_ctx_i
  , output logic                              req_yumi_o

  // tag pool
  , input  logic                              alloc_v_i
  , input  logic [tag_pkg::id_width_lp-1:0]   alloc_id_i
  , output logic                              alloc_yumi_o

  // context write
  , output logic                              ctx_we_o
  , output logic [tag_pkg::id_width_lp-1:0]   ctx_wid_o
  , output logic [tag_pkg::ctx_width_lp-1:0]  ctx_wdata_o

  // memory request, one cycle after the yumi
  , output logic                              mem_v_o
  , output logic [tag_pkg::addr_width_lp-1:0] mem_addr_o
  , output logic [tag_pkg::id_width_lp-1:0]   mem_id_o
);

  logic                              take_lo;
  logic                              mem_v_r;
  logic [tag_pkg::addr_width_lp-1:0] mem_addr_r;
  logic [tag_pkg::id_width_lp-1:0]   mem_id_r;

  // accept only while a tag is free
  assign take_lo      = req_v_i & alloc_v_i;
  assign req_yumi_o   = take_lo;
  assign alloc_yumi_o = take_lo;

  // context goes into the table under the offered tag
  assign ctx_we_o    = take_lo;
  assign ctx_wid_o   = alloc_id_i;
  assign ctx_wdata_o = req_ctx_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_v_r <= 1'b0;
    end else begin
      mem_v_r <= take_lo;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_lo) begin
      mem_addr_r <= req_addr_i;
      mem_id_r   <= alloc_id_i;
    end
  end

  assign mem_v_o    = mem_v_r;
  assign mem_addr_o = mem_addr_r;
  assign mem_id_o   = mem_id_r;

endmodule

//--- context_table.sv
`timescale 1ns/10ps

module context_table (
    input  logic                             clk_i

  // write port, from the issue side
  , input  logic                             we_i
  , input  logic [tag_pkg::id_width_lp-1:0]  wid_i
  , input  logic [tag_pkg::ctx_width_lp-1:0] wdata_i

  // read port, from the response side
  , input  logic [tag_pkg::id_width_lp-1:0]  rid_i
  , output logic [tag_pkg::ctx_width_lp-1:0] rdata_o
);

  // one context entry per tag
  logic [tag_pkg::ctx_width_lp-1:0] ctx_mem [tag_pkg::num_ids_lp];

  // entry written when its tag is handed out
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      ctx_mem[wid_i] <= wdata_i;
    end
  end

  // combinational read so the response finds its context on arrival
  assign rdata_o = ctx_mem[rid_i];

endmodule

//--- resp_merge.sv
`timescale 1ns/10ps

module resp_merge (
    input  logic                              clk_i
  , input  logic                              reset_i

  // memory response
  , input  logic                              mem_resp_v_i
  , input  logic [tag_pkg::id_width_lp-1:0]   mem_resp_id_i
  , input  logic [tag_pkg::data_width_lp-1:0] mem_resp_data_i

  // context lookup
  , output logic [tag_pkg::id_width_lp-1:0]   ctx_rid_o
  , input  logic [tag_pkg::ctx_width_lp-1:0]  ctx_rdata_i

  // tag release to the pool
  , output logic                              dealloc_v_o
  , output logic [tag_pkg::id_width_lp-1:0]   dealloc_id_o

  // merged result, one cycle after the response
  , output logic                              resp_v_o
  , output logic [tag_pkg::id_width_lp-1:0]   resp_id_o
  , output logic [tag_pkg::ctx_width_lp-1:0]  resp_ctx_o
  , output logic [tag_pkg::data_width_lp-1:0] resp_data_o
);

  logic                              resp_v_r;
  logic [tag_pkg::id_width_lp-1:0]   resp_id_r;
  logic [tag_pkg::ctx_width_lp-1:0]  resp_ctx_r;
  logic [tag_pkg::data_width_lp-1:0] resp_data_r;

  assign ctx_rid_o = mem_resp_id_i;

  // tag is free in the pool on the same edge the output is loaded
  assign dealloc_v_o  = mem_resp_v_i;
  assign dealloc_id_o = mem_resp_id_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else begin
      resp_v_r <= mem_resp_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_resp_v_i) begin
      resp_id_r   <= mem_resp_id_i;
      resp_ctx_r  <= ctx_rdata_i;
      resp_data_r <= mem_resp_data_i;
    end
  end

  assign resp_v_o    = resp_v_r;
  assign resp_id_o   = resp_id_r;
  assign resp_ctx_o  = resp_ctx_r;
  assign resp_data_o = resp_data_r;

endmodule

//--- tag_tracker.sv
`timescale 1ns/10ps

module tag_tracker (
    input  logic                              clk_i
  , input  logic                              reset_i

  // requester
  , input  logic                              req_v_i
  , input  logic [tag_pkg::addr_width_lp-1:0] req_addr_i
  , input  logic [tag_pkg::ctx_width_lp-1:0]  req_ctx_i
  , output logic                              req_yumi_o

  // memory request
  , output logic                              mem_v_o
  , output logic [tag_pkg::addr_width_lp-1:0] mem_addr_o
  , output logic [tag_pkg::id_width_lp-1:0]   mem_id_o

  // memory response, any order
  , input  logic                              mem_resp_v_i
  , input  logic [tag_pkg::id_width_lp-1:0]   mem_resp_id_i
  , input  logic [tag_pkg::data_width_lp-1:0] mem_resp_data_i

  // merged output
  , output logic                              resp_v_o
  , output logic [tag_pkg::id_width_lp-1:0]   resp_id_o
  , output logic [tag_pkg::ctx_width_lp-1:0]  resp_ctx_o
  , output logic [tag_pkg::data_width_lp-1:0] resp_data_o
);

  // pool to issue
  logic                             alloc_v_lo;
  logic [tag_pkg::id_width_lp-1:0]  alloc_id_lo;
  logic                             alloc_yumi_lo;

  // issue to table
  logic                             ctx_we_lo;
  logic [tag_pkg::id_width_lp-1:0]  ctx_wid_lo;
  logic [tag_pkg::ctx_width_lp-1:0] ctx_wdata_lo;

  // merge to table and pool
  logic [tag_pkg::id_width_lp-1:0]  ctx_rid_lo;
  logic [tag_pkg::ctx_width_lp-1:0] ctx_rdata_lo;
  logic                             dealloc_v_lo;
  logic [tag_pkg::id_width_lp-1:0]  dealloc_id_lo;

  id_pool pool_i (
     .clk_i        (clk_i)
    ,.reset_i      (reset_i)
    ,.alloc_v_o    (alloc_v_lo)
    ,.alloc_id_o   (alloc_id_lo)
    ,.alloc_yumi_i (alloc_yumi_lo)
    ,.dealloc_v_i  (dealloc_v_lo)
    ,.dealloc_id_i (dealloc_id_lo)
  );

  req_issue issue_i (
     .clk_i        (clk_i)
    ,.reset_i      (reset_i)
    ,.req_v_i      (req_v_i)
    ,.req_addr_i   (req_addr_i)
    ,.req_ctx_i    (req_ctx_i)
    ,.req_yumi_o   (req_yumi_o)
    ,.alloc_v_i    (alloc_v_lo)
    ,.alloc_id_i   (alloc_id_lo)
    ,.alloc_yumi_o (alloc_yumi_lo)
    ,.ctx_we_o     (ctx_we_lo)
    ,.ctx_wid_o    (ctx_wid_lo)
    ,.ctx_wdata_o  (ctx_wdata_lo)
    ,.mem_v_o      (mem_v_o)
    ,.mem_addr_o   (mem_addr_o)
    ,.mem_id_o     (mem_id_o)
  );

  context_table ctx_table_i (
     .clk_i   (clk_i)
    ,.we_i    (ctx_we_lo)
    ,.wid_i   (ctx_wid_lo)
    ,.wdata_i (ctx_wdata_lo)
    ,.rid_i   (ctx_rid_lo)
    ,.rdata_o (ctx_rdata_lo)
  );

  resp_merge merge_i (
     .clk_i           (clk_i)
    ,.reset_i         (reset_i)
    ,.mem_resp_v_i    (mem_resp_v_i)
    ,.mem_resp_id_i   (mem_resp_id_i)
    ,.mem_resp_data_i (mem_resp_data_i)
    ,.ctx_rid_o       (ctx_rid_lo)
    ,.ctx_rdata_i     (ctx_rdata_lo)
    ,.dealloc_v_o     (dealloc_v_lo)
    ,.dealloc_id_o    (dealloc_id_lo)
    ,.resp_v_o        (resp_v_o)
    ,.resp_id_o       (resp_id_o)
    ,.resp_ctx_o      (resp_ctx_o)
    ,.resp_data_o     (resp_data_o)
  );

endmodule

//--- tag_tracker_assert.sv
`timescale 1ns/10ps

module tag_tracker_assert (
    input logic clk_i
  , input logic reset_i
  , input logic req_v_i
  , input logic req_yumi_i
  , input logic mem_v_i
  , input logic mem_resp_v_i
  , input logic resp_v_i
);

  // running count of failed properties
  int unsigned fail_cnt = 0;

  // yumi only answers a valid request
  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      req_yumi_i |-> req_v_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("req_yumi_o high while req_v_i is low");
    end

  // memory request exactly one cycle after each yumi
  mem_after_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
      req_yumi_i |=> mem_v_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("mem_v_o missing one cycle after req_yumi_o");
    end

  mem_only_after_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
      !req_yumi_i |=> !mem_v_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("mem_v_o high without a yumi in the cycle before");
    end

  // merged output exactly one cycle after each memory response
  resp_after_mem: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_resp_v_i |=> resp_v_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("resp_v_o missing one cycle after mem_resp_v_i");
    end

  resp_only_after_mem: assert property (@(posedge clk_i) disable iff (reset_i)
      !mem_resp_v_i |=> !resp_v_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("resp_v_o high without a memory response in the cycle before");
    end

endmodule

bind tag_tracker tag_tracker_assert assert_i (
   .clk_i        (clk_i)
  ,.reset_i      (reset_i)
  ,.req_v_i      (req_v_i)
  ,.req_yumi_i   (req_yumi_o)
  ,.mem_v_i      (mem_v_o)
  ,.mem_resp_v_i (mem_resp_v_i)
  ,.resp_v_i     (resp_v_o)
);

//--- tag_tracker_tb.sv
`timescale 1ns/10ps

module tag_tracker_tb;

  logic                              clk;
  logic                              reset;
  logic                              req_v;
  logic [tag_pkg::addr_width_lp-1:0] req_addr;
  logic [tag_pkg::ctx_width_lp-1:0]  req_ctx;
  logic                              req_yumi;
  logic                              mem_v;
  logic [tag_pkg::addr_width_lp-1:0] mem_addr;
  logic [tag_pkg::id_width_lp-1:0]   mem_id;
  logic                              mem_resp_v;
  logic [tag_pkg::id_width_lp-1:0]   mem_resp_id;
  logic [tag_pkg::data_width_lp-1:0] mem_resp_data;
  logic                              resp_v;
  logic [tag_pkg::id_width_lp-1:0]   resp_id;
  logic [tag_pkg::ctx_width_lp-1:0]  resp_ctx;
  logic [tag_pkg::data_width_lp-1:0] resp_data;

  // tags held by the tracker and tags waiting at memory
  logic [tag_pkg::num_ids_lp-1:0]    busy;
  logic [tag_pkg::num_ids_lp-1:0]    mem_pending;
  logic [tag_pkg::ctx_width_lp-1:0]  sb_ctx [tag_pkg::num_ids_lp];
  logic [tag_pkg::addr_width_lp-1:0] sb_addr [tag_pkg::num_ids_lp];

  // what the outputs must show after the next edge
  logic                              exp_mem_v;
  logic [tag_pkg::id_width_lp-1:0]   exp_mem_id;
  logic [tag_pkg::addr_width_lp-1:0] exp_mem_addr;
  logic                              exp_resp_v;
  logic [tag_pkg::id_width_lp-1:0]   exp_resp_id;
  logic [tag_pkg::ctx_width_lp-1:0]  exp_resp_ctx;
  logic [tag_pkg::data_width_lp-1:0] exp_resp_data;

  logic        last_taken;
  logic [15:0] lfsr_q;
  int          error_count;
  int          err_mark;
  int          assert_mark;
  int          tests_passed;
  int          tests_failed;
  int          random_cycles = 300;
  int          ooo_order [8] = '{3, 0, 7, 1, 6, 2, 4, 5};

  tag_tracker tag_tracker_i (
     .clk_i           (clk)
    ,.reset_i         (reset)
    ,.req_v_i         (req_v)
    ,.req_addr_i      (req_addr)
    ,.req_ctx_i       (req_ctx)
    ,.req_yumi_o      (req_yumi)
    ,.mem_v_o         (mem_v)
    ,.mem_addr_o      (mem_addr)
    ,.mem_id_o        (mem_id)
    ,.mem_resp_v_i    (mem_resp_v)
    ,.mem_resp_id_i   (mem_resp_id)
    ,.mem_resp_data_i (mem_resp_data)
    ,.resp_v_o        (resp_v)
    ,.resp_id_o       (resp_id)
    ,.resp_ctx_o      (resp_ctx)
    ,.resp_data_o     (resp_data)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] exp_val,
                          input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
      error_count++;
    end
  endtask

  // galois lfsr stepped once per bit taken
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      v = {v[14:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // scans downward so the lowest clear bit is the last one kept
  function automatic logic lowest_free(input logic [tag_pkg::num_ids_lp-1:0] taken,
                                       output logic [tag_pkg::id_width_lp-1:0] id);
    logic found;
    found = 1'b0;
    id = '0;
    for (int t = tag_pkg::num_ids_lp - 1; t >= 0; t--) begin
      if (!taken[t]) begin
        found = 1'b1;
        id = t[tag_pkg::id_width_lp-1:0];
      end
    end
    return found;
  endfunction

  function automatic int assert_failures();
    return int'(tag_tracker_i.assert_i.fail_cnt);
  endfunction

  // one clock cycle of checking the last edge and driving the next inputs
  task automatic step(input logic rv, input logic [tag_pkg::addr_width_lp-1:0] raddr,
                      input logic [tag_pkg::ctx_width_lp-1:0] rctx,
                      input logic mv, input logic [tag_pkg::id_width_lp-1:0] mid);
    logic                            free_v;
    logic [tag_pkg::id_width_lp-1:0] free_id;
    @(negedge clk);
    check_eq("mem_v_o", 32'(exp_mem_v), 32'(mem_v));
    if (exp_mem_v) begin
      check_eq("mem_id_o", 32'(exp_mem_id), 32'(mem_id));
      check_eq("mem_addr_o", 32'(exp_mem_addr), 32'(mem_addr));
      check_eq("mem_id_o reissued while outstanding", 0, 32'(mem_pending[mem_id]));
      mem_pending[exp_mem_id] = 1'b1;
      busy[exp_mem_id] = 1'b1;
    end
    check_eq("resp_v_o", 32'(exp_resp_v), 32'(resp_v));
    if (exp_resp_v) begin
      check_eq("resp_id_o", 32'(exp_resp_id), 32'(resp_id));
      check_eq("resp_ctx_o", 32'(exp_resp_ctx), 32'(resp_ctx));
      check_eq("resp_data_o", exp_resp_data, resp_data);
      busy[exp_resp_id] = 1'b0;
    end
    req_v = rv;
    req_addr = raddr;
    req_ctx = rctx;
    mem_resp_v = mv;
    mem_resp_id = mid;
    // memory answers with the address twice
    mem_resp_data = {sb_addr[mid], sb_addr[mid]};
    if (mv) begin
      mem_pending[mid] = 1'b0;
    end
    #1;
    free_v = lowest_free(busy, free_id);
    check_eq("req_yumi_o", 32'(rv & free_v), 32'(req_yumi));
    last_taken = req_yumi;
    exp_resp_v = mv;
    exp_resp_id = mid;
    exp_resp_ctx = sb_ctx[mid];
    exp_resp_data = {sb_addr[mid], sb_addr[mid]};
    exp_mem_v = rv & free_v;
    exp_mem_id = free_id;
    exp_mem_addr = raddr;
    if (rv & free_v) begin
      sb_ctx[free_id] = rctx;
      sb_addr[free_id] = raddr;
    end
  endtask

  task automatic idle();
    step(1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic run_random(input int cycles);
    logic                              cur_v;
    logic [tag_pkg::addr_width_lp-1:0] cur_addr;
    logic [tag_pkg::ctx_width_lp-1:0]  cur_ctx;
    logic                              ans_v;
    logic [tag_pkg::id_width_lp-1:0]   ans_id;
    logic [tag_pkg::id_width_lp-1:0]   start;
    logic [tag_pkg::id_width_lp-1:0]   cand;
    logic [15:0]                       r;
    cur_v = 1'b0;
    cur_addr = '0;
    cur_ctx = '0;
    for (int n = 0; n < cycles; n++) begin
      // requester holds its fields until taken
      if (!cur_v || last_taken) begin
        r = take_bits(1);
        cur_v = r[0];
        cur_addr = take_bits(16);
        r = take_bits(8);
        cur_ctx = r[7:0];
      end
      ans_v = 1'b0;
      ans_id = '0;
      r = take_bits(1);
      if (r[0] && mem_pending != '0) begin
        r = take_bits(3);
        start = r[2:0];
        for (int k = 0; k < tag_pkg::num_ids_lp; k++) begin
          cand = start + 3'(k);
          if (!ans_v && mem_pending[cand]) begin
            ans_v = 1'b1;
            ans_id = cand;
          end
        end
      end
      step(cur_v, cur_addr, cur_ctx, ans_v, ans_id);
    end
  endtask

  // answer everything still at memory in lowest tag order
  task automatic drain();
    logic [tag_pkg::id_width_lp-1:0] id;
    logic                            found;
    idle();
    idle();
    while (mem_pending != '0) begin
      found = lowest_free(~mem_pending, id);
      step(1'b0, '0, '0, found, id);
    end
    idle();
  endtask

  task automatic begin_test();
    err_mark = error_count;
    assert_mark = assert_failures();
  endtask

  task automatic end_test(input string name);
    if (error_count == err_mark && assert_failures() == assert_mark) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed", name);
    end
  endtask

  initial begin
    req_v = 1'b0;
    req_addr = '0;
    req_ctx = '0;
    mem_resp_v = 1'b0;
    mem_resp_id = '0;
    mem_resp_data = '0;
    reset = 1'b1;
    lfsr_q = 16'd84;
    busy = '0;
    mem_pending = '0;
    exp_mem_v = 1'b0;
    exp_resp_v = 1'b0;
    last_taken = 1'b0;
    error_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    begin_test();
    check_eq("mem_v_o", 0, 32'(mem_v));
    check_eq("resp_v_o", 0, 32'(resp_v));
    for (int i = 0; i < 4; i++) begin
      step(1'b1, 16'h1000 + 16'(i), 8'h10 + 8'(i), 1'b0, '0);
    end
    idle();
    end_test("reset and lowest-free order");

    begin_test();
    for (int i = 4; i < 8; i++) begin
      step(1'b1, 16'h2400 + 16'(i * 3), 8'h80 + 8'(i), 1'b0, '0);
    end
    idle();
    end_test("memory request timing");

    begin_test();
    repeat (3) step(1'b1, 16'hbeef, 8'h5a, 1'b0, '0);
    step(1'b1, 16'hbeef, 8'h5a, 1'b1, 3'd5);
    step(1'b1, 16'hbeef, 8'h5a, 1'b0, '0);
    check_eq("req_yumi_o after release", 1, 32'(last_taken));
    idle();
    end_test("pool exhaustion");

    begin_test();
    for (int i = 0; i < 8; i++) begin
      step(1'b0, '0, '0, 1'b1, 3'(ooo_order[i]));
    end
    idle();
    end_test("out-of-order responses");

    begin_test();
    run_random(random_cycles);
    drain();
    end_test("random traffic");

    $display("tests passed: %0d, tests failed: %0d, check errors: %0d, assertion failures: %0d",
             tests_passed, tests_failed, error_count, assert_failures());
    if (tests_failed == 0 && error_count == 0 && assert_failures() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // cycles for reset, directed tests, random traffic, drain and a margin
  initial begin
    #((5 + 40 + random_cycles + 20 + 100) * 100);
    $display("timeout: the tests did not finish in the expected number of cycles");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- tag_tracker.f
tag_pkg.sv
id_pool.sv
req_issue.sv
context_table.sv
resp_merge.sv
tag_tracker.sv
tag_tracker_assert.sv
tag_tracker_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tag_tracker_tb -f tag_tracker.f -o tag_tracker_sim \
  || { echo "verilator build failed"; exit 1; }

# run past assertion errors so the testbench reaches its summary
sim_out=$(./obj_dir/tag_tracker_sim +verilator+error+limit+1000 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -q "RESULT: PASS" \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
